//--- compile.f
source/reg_main_pkg.sv
source/reg_access_decode.sv
source/capture_ctrl_regs.sv
source/sniff_fifo_reader.sv
source/read_data_port.sv
source/reg_main_top.sv
dv/reg_main_properties.sv
dv/reg_main_tb.sv

//--- run_sim.sh
#!/bin/bash
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module reg_main_tb \
   -f compile.f -o reg_main_sim > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/reg_main_sim > sim.log 2>&1 || { echo "simulation stopped with an error"; exit 1; }
grep -q "TESTS FAILED" sim.log && { echo "failures reported, see sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

//--- dv/reg_main_tb.sv
/* testbench for the main register block. random register traffic and sniff FIFO
   bursts are checked against a shadow model, and the FWFT FIFO itself lives here */

`default_nettype none

module reg_main_tb
   import reg_main_pkg::*;
();

   localparam bit qs_default = 1'b0;
   localparam int n_rand     = 200;
   localparam int n_sel      = 20;
   localparam int n_words    = 8;
   localparam int n_refill   = 3;
   // cycle budget of each test, in run order
   localparam int total_cycles = 160 + n_rand * 7 + n_sel * 10 + 40
                               + (n_words + n_refill + 1) * 13 + 20;

   logic         cwusb_clk;
   logic         fpga_reset;
   reg_bus_t     bus;
   fifo_in_t     fifo;
   logic         flushing;
   logic         capture_enable_pulse;
   logic [7:0]   read_data;
   logic         selected;
   logic         fifo_read;
   capture_cfg_t cfg;
   logic         arm;
   logic         reg_arm;
   logic         arm_pulse;
   logic         capture_now;

   int           errors = 0;
   int           checks = 0;
   int           pops = 0;
   logic [31:0]  rng_state = 32'h6b6d2974;
   logic [17:0]  fifo_q[$];     // head drives fifo.data
   logic [5:0]   status_val;
   capture_cfg_t m_cfg;         // shadow of the config registers
   logic         m_arm;

   reg_main_top #(.quick_start_default(qs_default)) i_dut (.*);

   initial cwusb_clk = 1'b0;
   always #50 cwusb_clk = ~cwusb_clk;

   // FWFT FIFO, pops on the fifo_read seen at the edge
   always @(posedge cwusb_clk) begin
      if (fifo_read) begin
         pops++;
         if (fifo_q.size() == 0) begin
            errors++;
            $display("error at %0t: FIFO popped while it holds no data", $time);
         end else begin
            void'(fifo_q.pop_front());
         end
      end
      fifo <= '{data: (fifo_q.size() > 0) ? fifo_q[0] : 18'h0, status: status_val,
                empty: (fifo_q.size() == 0)};
   end

   initial begin
      #(total_cycles * 150);   // 1.5 times the budget
      $display("timeout: the tests did not finish within %0d cycles", total_cycles * 3 / 2);
      $display("TESTS FAILED");
      $finish;
   end

   ////////////////////
   // helpers
   ////////////////////

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic compare_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      end
   endtask

   // one bus cycle, then idle; returns read_data once the output register has it
   task automatic bus_access(input logic [1:0] sel, input logic valid, input logic [5:0] off,
                             input logic [6:0] bc, input logic [7:0] d, input logic wr,
                             output logic [7:0] rdata);
      @(posedge cwusb_clk);
      bus <= '{address: {sel, off}, bytecnt: bc, write_data: d, read: ~wr, write: wr,
               addrvalid: valid};
      @(negedge cwusb_clk);
      compare_value("selected", 64'(valid && (sel == 2'd0)), 64'(selected));   // block code 0
      @(posedge cwusb_clk);
      bus <= '0;
      @(negedge cwusb_clk);
      rdata = read_data;
   endtask

   function automatic logic [7:0] model_byte(input logic [5:0] off, input logic [6:0] bc);
      case (off)
         6'd0:    return 8'(m_cfg.fe_select);
         6'd1:    return 8'(m_arm);
         6'd2:    return 8'(m_cfg.trigger_enable);
         6'd3:    return 8'(m_cfg.num_triggers);
         6'd4:    return (bc < 3) ? 8'(m_cfg.capture_len >> (8 * bc)) : 8'h0;
         6'd5:    return 8'(m_cfg.count_writes);
         6'd6:    return 8'(m_cfg.counter_quick_start);
         6'd7:    return 8'(m_cfg.capture_while_trig);
         6'd8:    return (bc < 2) ? 8'(m_cfg.max_timestamp >> (8 * bc)) : 8'h0;
         6'd9:    return 8'(status_val);   // FIFO status, zero-extended
         default: return 8'h0;
      endcase
   endfunction

   function automatic void model_write(input logic [5:0] off, input logic [6:0] bc,
                                       input logic [7:0] d);
      case (off)
         6'd0: m_cfg.fe_select = d[1:0];
         6'd2: m_cfg.trigger_enable = d[0];
         6'd3: m_cfg.num_triggers = d[3:0];
         6'd4: if (bc < 3) m_cfg.capture_len[8 * bc +: 8] = d;
         6'd5: m_cfg.count_writes = d[0];
         6'd6: m_cfg.counter_quick_start = d[0];
         6'd7: m_cfg.capture_while_trig = d[0];
         6'd8: if (bc < 2) m_cfg.max_timestamp[8 * bc +: 8] = d;
         default: ;   // read-only or unmapped
      endcase
   endfunction

   // 4-byte burst on the FIFO register, w is the word it must return
   task automatic read_burst(input logic [17:0] w);
      logic [7:0] b [4];
      logic [7:0] d;
      logic [6:0] base;
      b    = '{8'h0, w[7:0], w[15:8], {status_val, w[17:16]}};
      base = 7'(next_rand()) & 7'h7c;   // any burst-aligned count
      for (int k = 0; k < 4; k++) begin
         bus_access(2'd0, 1'b1, reg_sniff_fifo_rd, base + 7'(k), 8'h0, 1'b0, d);
         compare_value("read_data", 64'(b[k]), 64'(d));
      end
   endtask

   ////////////////////
   // tests
   ////////////////////

   initial begin
      int          err_mark;
      logic [31:0] r;
      logic [5:0]  off;
      logic [6:0]  bc;
      logic [1:0]  sel_bad;
      logic [7:0]  d;
      logic [17:0] exp_q[$];
      status_val           = 6'(next_rand());
      fpga_reset           = 1'b1;
      bus                  = '0;
      fifo                 = '{data: 18'h0, status: status_val, empty: 1'b1};
      flushing             = 1'b0;
      capture_enable_pulse = 1'b0;
      m_cfg = '{fe_select: fe_usb, capture_len: '0, trigger_enable: 1'b0, num_triggers: 4'd1,
                count_writes: 1'b0, counter_quick_start: qs_default, capture_while_trig: 1'b0,
                max_timestamp: 16'hffff};
      m_arm = 1'b0;
      repeat (2) @(posedge cwusb_clk);
      fpga_reset <= 1'b0;

      err_mark = errors;
      @(negedge cwusb_clk);
      compare_value("cfg", 64'(m_cfg), 64'(cfg));
      compare_value("{reg_arm,arm,arm_pulse,capture_now,fifo_read}", 64'(0),
                    64'({reg_arm, arm, arm_pulse, capture_now, fifo_read}));
      for (int o = 0; o < 10; o++) begin
         for (int k = 0; k < 4; k++) begin
            bus_access(2'd0, 1'b1, 6'(o), 7'(k), 8'h0, 1'b0, d);
            compare_value("read_data", 64'(model_byte(6'(o), 7'(k))), 64'(d));
         end
      end
      $display("test reset_values finished, %0d errors", errors - err_mark);

      err_mark = errors;
      for (int i = 0; i < n_rand; i++) begin
         r   = next_rand();
         off = (r[3:0] == 4'd1 || r[3:0] == 4'd10) ? 6'd4 : 6'(r[3:0]);   // no arm or pop
         bc  = 7'(r[6:4]);
         bus_access(2'd0, 1'b1, off, bc, r[15:8], 1'b1, d);
         model_write(off, bc, r[15:8]);
         bus_access(2'd0, 1'b1, off, bc, 8'h0, 1'b0, d);
         compare_value("read_data", 64'(model_byte(off, bc)), 64'(d));
         compare_value("cfg", 64'(m_cfg), 64'(cfg));
      end
      $display("test random_rw finished, %0d errors", errors - err_mark);

      err_mark = errors;
      for (int i = 0; i < n_sel; i++) begin
         r       = next_rand();
         off     = (r[3:0] == 4'd1 || r[3:0] == 4'd10) ? 6'd8 : 6'(r[3:0]);
         bc      = 7'(r[6:4]);
         sel_bad = r[16] ? 2'd0 : ((r[18:17] == 2'd0) ? 2'd2 : r[18:17]);   // r[16] drops valid
         bus_access(sel_bad, ~r[16], off, bc, r[15:8], 1'b1, d);
         bus_access(sel_bad, ~r[16], off, bc, 8'h0, 1'b0, d);
         compare_value("read_data", 64'(0), 64'(d));
         compare_value("cfg", 64'(m_cfg), 64'(cfg));
         bus_access(2'd0, 1'b1, off, bc, 8'h0, 1'b0, d);
         compare_value("read_data", 64'(model_byte(off, bc)), 64'(d));
      end
      $display("test block_select finished, %0d errors", errors - err_mark);

      err_mark = errors;
      bus_access(2'd0, 1'b1, 6'd1, 7'd0, 8'h01, 1'b1, d);
      compare_value("{reg_arm,arm,arm_pulse,capture_now}", 64'(4'b1010),
                    64'({reg_arm, arm, arm_pulse, capture_now}));
      @(negedge cwusb_clk);
      compare_value("{reg_arm,arm,arm_pulse,capture_now}", 64'(4'b1100),
                    64'({reg_arm, arm, arm_pulse, capture_now}));
      bus_access(2'd0, 1'b1, 6'd1, 7'd0, 8'h02, 1'b1, d);   // capture-now only
      compare_value("capture_now", 64'(1), 64'(capture_now));
      @(negedge cwusb_clk);
      compare_value("capture_now", 64'(0), 64'(capture_now));
      @(posedge cwusb_clk);
      flushing <= 1'b1;
      @(negedge cwusb_clk);
      compare_value("{reg_arm,arm}", 64'(2'b10), 64'({reg_arm, arm}));
      @(posedge cwusb_clk);
      flushing             <= 1'b0;
      capture_enable_pulse <= 1'b1;
      @(posedge cwusb_clk);
      capture_enable_pulse <= 1'b0;
      @(negedge cwusb_clk);
      compare_value("{reg_arm,arm}", 64'(2'b01), 64'({reg_arm, arm}));   // arm lags a cycle
      // arm write and clear in the same cycle
      @(posedge cwusb_clk);
      bus <= '{address: 8'd1, bytecnt: '0, write_data: 8'h01, read: 1'b0, write: 1'b1,
               addrvalid: 1'b1};
      capture_enable_pulse <= 1'b1;
      @(posedge cwusb_clk);
      bus                  <= '0;
      capture_enable_pulse <= 1'b0;
      m_arm = 1'b1;
      @(negedge cwusb_clk);
      compare_value("{reg_arm,arm_pulse}", 64'(2'b11), 64'({reg_arm, arm_pulse}));
      bus_access(2'd0, 1'b1, 6'd1, 7'd0, 8'h0, 1'b0, d);
      compare_value("read_data", 64'(model_byte(6'd1, 7'd0)), 64'(d));
      $display("test arm_control finished, %0d errors", errors - err_mark);

      err_mark = errors;
      for (int i = 0; i < n_words + n_refill; i++) begin
         exp_q.push_back(18'(next_rand()));
         if (i < n_words)
            fifo_q.push_back(exp_q[i]);
      end
      repeat (3) @(negedge cwusb_clk);   // empty flag settles
      for (int i = 0; i < n_words; i++)
         read_burst(exp_q.pop_front());
      read_burst({fifo_cmd_strm, fifo_strm_empty});   // started on an empty FIFO
      for (int i = 0; i < n_refill; i++)
         fifo_q.push_back(exp_q[i]);
      repeat (3) @(negedge cwusb_clk);
      for (int i = 0; i < n_refill; i++)
         read_burst(exp_q.pop_front());
      compare_value("pop_count", 64'(n_words + n_refill), 64'(pops));
      $display("test fifo_read finished, %0d errors", errors - err_mark);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/reg_main_properties.sv
/* concurrent checks on the strobe outputs of the register block,
   bound into the top level */

`default_nettype none

module reg_main_properties
   import reg_main_pkg::*;
(
   input wire           cwusb_clk,
   input wire           fpga_reset,
   input wire fifo_in_t fifo,
   input wire           fifo_read,
   input wire           arm_pulse,
   input wire           capture_now
);

   // single-cycle strobes
   a_arm_pulse_single: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      arm_pulse |=> !arm_pulse)
      else $error("arm_pulse high on two consecutive cycles");

   a_capture_now_single: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      capture_now |=> !capture_now)
      else $error("capture_now high on two consecutive cycles");

   a_no_pop_when_empty: assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      $past(fifo.empty) |-> !fifo_read)
      else $error("fifo_read while the FIFO was empty one cycle earlier");

   // first cycle out of reset
   a_quiet_after_reset: assert property (@(posedge cwusb_clk)
      $fell(fpga_reset) |-> !(fifo_read || arm_pulse || capture_now))
      else $error("strobe active in the cycle after reset");

endmodule

bind reg_main_top reg_main_properties i_props (.*);

`default_nettype wire

//--- source/reg_main_top.sv
/* main register block of the capture board.
   decodes the USB register bus, holds the config and arm registers, reads the sniff FIFO */

`default_nettype none

module reg_main_top
   import reg_main_pkg::*;
#(
   parameter logic [1:0] reg_select          = 2'd0,
   parameter bit         quick_start_default = 1'b0,
   parameter bit         registered_read     = 1'b1
) (
   input  wire            cwusb_clk,
   input  wire            fpga_reset,
   input  wire reg_bus_t  bus,
   input  wire fifo_in_t  fifo,
   input  wire            flushing,
   input  wire            capture_enable_pulse,
   output logic [7:0]     read_data,
   output logic           selected,
   output logic           fifo_read,
   output capture_cfg_t   cfg,
   output logic           arm,
   output logic           reg_arm,
   output logic           arm_pulse,
   output logic           capture_now
);

   reg_access_t access;
   logic [7:0]  cfg_byte;
   logic [7:0]  fifo_byte;
   logic        fifo_sel;

   ////////////////////
   // input side
   ////////////////////

   reg_access_decode #(
      .reg_select (reg_select)
   ) u_decode (
      .cwusb_clk  (cwusb_clk),
      .fpga_reset (fpga_reset),
      .bus        (bus),
      .access     (access),
      .selected   (selected)
   );

   ////////////////////
   // registers
   ////////////////////

   capture_ctrl_regs #(
      .quick_start_default (quick_start_default)
   ) u_ctrl_regs (
      .cwusb_clk            (cwusb_clk),
      .fpga_reset           (fpga_reset),
      .access               (access),
      .capture_enable_pulse (capture_enable_pulse),
      .flushing             (flushing),
      .fifo_status          (fifo.status),
      .cfg                  (cfg),
      .cfg_byte             (cfg_byte),
      .reg_arm              (reg_arm),
      .arm                  (arm),
      .arm_pulse            (arm_pulse),
      .capture_now          (capture_now)
   );

   ////////////////////
   // output side
   ////////////////////

   sniff_fifo_reader u_fifo_reader (
      .cwusb_clk  (cwusb_clk),
      .fpga_reset (fpga_reset),
      .access     (access),
      .fifo       (fifo),
      .fifo_read  (fifo_read),
      .fifo_byte  (fifo_byte),
      .fifo_sel   (fifo_sel)
   );

   read_data_port #(
      .registered_read (registered_read)
   ) u_read_port (
      .cwusb_clk (cwusb_clk),
      .cfg_byte  (cfg_byte),
      .fifo_byte (fifo_byte),
      .fifo_sel  (fifo_sel),
      .read_data (read_data)
   );

endmodule

`default_nettype wire

//--- source/read_data_port.sv
/* read data output: FIFO byte or register byte, with an optional
   output register that adds one cycle of latency */

`default_nettype none

module read_data_port #(
   parameter bit registered_read = 1'b1
) (
   input  wire        cwusb_clk,
   input  wire [7:0]  cfg_byte,
   input  wire [7:0]  fifo_byte,
   input  wire        fifo_sel,
   output logic [7:0] read_data
);

   logic [7:0] read_pre;
   logic [7:0] read_data_r;

   // FIFO register takes the FIFO byte, everything else the config byte
   assign read_pre = fifo_sel ? fifo_byte : cfg_byte;

   // eases timing toward the USB pins
   always_ff @(posedge cwusb_clk) begin
      read_data_r <= read_pre;
   end

   assign read_data = registered_read ? read_data_r : read_pre;

endmodule

`default_nettype wire

//--- source/sniff_fifo_reader.sv
/* register-bus reader for the sniff FIFO.
   byte 0 of each 4-byte burst pops a word, bytes 1 to 3 return it with the status */

`default_nettype none

module sniff_fifo_reader
   import reg_main_pkg::*;
(
   input  wire               cwusb_clk,
   input  wire               fpga_reset,
   input  wire reg_access_t  access,
   input  wire fifo_in_t     fifo,
   output logic              fifo_read,
   output logic [7:0]        fifo_byte,
   output logic              fifo_sel
);

   logic        fifo_empty_r;   // empty flag, one cycle old
   logic        empty_read;     // current burst started on an empty FIFO
   logic        burst_start;
   logic [17:0] word_r;         // word captured on the pop
   logic [17:0] word;

   assign fifo_sel = (access.addr == reg_sniff_fifo_rd);

   // first cycle of a read of byte 0 (mod 4)
   assign burst_start = access.rd_first && fifo_sel && (access.bytecnt[1:0] == 2'd0);

   // no pop when the FIFO was empty, the marker goes out instead
   assign fifo_read = burst_start & ~fifo_empty_r;

   ////////////////////
   // flags
   ////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         fifo_empty_r <= 1'b1;   // no pop right out of reset
         empty_read   <= 1'b0;
      end else begin
         fifo_empty_r <= fifo.empty;
         if (burst_start)
            empty_read <= fifo_empty_r;
      end
   end

   // FWFT, data is valid in the pop cycle
   always_ff @(posedge cwusb_clk) begin
      if (fifo_read)
         word_r <= fifo.data;
   end

   ////////////////////
   // byte select
   ////////////////////

   assign word = empty_read ? fifo_empty_word : word_r;

   always_comb begin
      fifo_byte = 8'h00;
      if (access.rd && fifo_sel) begin
         case (access.bytecnt[1:0])
            2'd1:    fifo_byte = word[7:0];
            2'd2:    fifo_byte = word[15:8];
            2'd3:    fifo_byte = {fifo.status, word[17:16]};   // live status on top
            default: fifo_byte = 8'h00;                        // pop byte
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/capture_ctrl_regs.sv
/* configuration registers, arm control and register readback byte.
   written one byte per bus cycle, wide registers indexed by the byte count */

`default_nettype none

module capture_ctrl_regs
   import reg_main_pkg::*;
#(
   parameter bit quick_start_default = 1'b0
) (
   input  wire               cwusb_clk,
   input  wire               fpga_reset,
   input  wire reg_access_t  access,
   input  wire               capture_enable_pulse,
   input  wire               flushing,
   input  wire [5:0]         fifo_status,
   output capture_cfg_t      cfg,
   output logic [7:0]        cfg_byte,
   output logic              reg_arm,
   output logic              arm,
   output logic              arm_pulse,
   output logic              capture_now
);

   logic arm_wr;            // write to the arm register
   logic reg_arm_r;
   logic capture_now_req;
   logic capture_now_r;

   // byte idx of a wide register, 0 past its width
   function automatic logic [7:0] pick_byte(input logic [31:0]          value,
                                            input int unsigned          nbytes,
                                            input logic [bytecnt_w-1:0] idx);
      logic [7:0] b;
      b = value[idx[1:0]*8 +: 8];
      pick_byte = (idx < nbytes) ? b : 8'h00;
   endfunction

   // the port reg_arm hides the enum literal of the same name
   assign arm_wr = access.wr && (access.addr == reg_main_pkg::reg_arm);

   ////////////////////
   // config writes
   ////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         cfg <= '{fe_select:           fe_usb,
                  capture_len:         '0,
                  trigger_enable:      1'b0,
                  num_triggers:        num_triggers_w'(1),
                  count_writes:        1'b0,
                  counter_quick_start: quick_start_default,
                  capture_while_trig:  1'b0,
                  max_timestamp:       '1};
      end else if (access.wr) begin
         case (access.addr)
            reg_fe_select:           cfg.fe_select <= access.data[fe_select_w-1:0];
            reg_trigger_enable:      cfg.trigger_enable <= access.data[0];
            reg_num_triggers:        cfg.num_triggers <= access.data[num_triggers_w-1:0];
            reg_count_writes:        cfg.count_writes <= access.data[0];
            reg_counter_quick_start: cfg.counter_quick_start <= access.data[0];
            reg_capture_while_trig:  cfg.capture_while_trig <= access.data[0];
            reg_capture_len: begin
               if (access.bytecnt < capture_len_w / 8)
                  cfg.capture_len[access.bytecnt[1:0]*8 +: 8] <= access.data;
            end
            reg_max_timestamp: begin
               if (access.bytecnt < max_timestamp_w / 8)
                  cfg.max_timestamp[access.bytecnt[0]*8 +: 8] <= access.data;
            end
            default: ;   // unmapped, write dropped
         endcase
      end
   end

   ////////////////////
   // arm control
   ////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         reg_arm         <= 1'b0;
         reg_arm_r       <= 1'b0;
         capture_now_req <= 1'b0;
         capture_now_r   <= 1'b0;
      end else begin
         reg_arm_r       <= reg_arm;
         capture_now_req <= arm_wr & access.data[1];
         capture_now_r   <= capture_now_req;
         if (arm_wr) begin
            if (access.data[0])
               reg_arm <= 1'b1;   // a write in the same cycle beats the clear
         end else if (capture_enable_pulse) begin
            reg_arm <= 1'b0;
         end
      end
   end

   assign arm_pulse   = reg_arm & ~reg_arm_r;
   assign capture_now = capture_now_req & ~capture_now_r;   // one cycle per burst of writes
   assign arm         = reg_arm_r & ~flushing;

   ////////////////////
   // readback
   ////////////////////

   always_comb begin
      cfg_byte = 8'h00;
      if (access.rd) begin
         case (access.addr)
            reg_fe_select:           cfg_byte = 8'(cfg.fe_select);
            reg_main_pkg::reg_arm:   cfg_byte = {7'b0, reg_arm};
            reg_trigger_enable:      cfg_byte = {7'b0, cfg.trigger_enable};
            reg_num_triggers:        cfg_byte = 8'(cfg.num_triggers);
            reg_count_writes:        cfg_byte = {7'b0, cfg.count_writes};
            reg_counter_quick_start: cfg_byte = {7'b0, cfg.counter_quick_start};
            reg_capture_while_trig:  cfg_byte = {7'b0, cfg.capture_while_trig};
            reg_capture_len:
               cfg_byte = pick_byte(32'(cfg.capture_len), capture_len_w / 8, access.bytecnt);
            reg_max_timestamp:
               cfg_byte = pick_byte(32'(cfg.max_timestamp), max_timestamp_w / 8,
                                    access.bytecnt);
            reg_sniff_fifo_stat:     cfg_byte = {2'b00, fifo_status};
            default:                 cfg_byte = 8'h00;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/reg_access_decode.sv
/* block select and read/write strobe decode for the register bus.
   every other module sees the bus only through the decoded access struct */

`default_nettype none

module reg_access_decode
   import reg_main_pkg::*;
#(
   parameter logic [1:0] reg_select = 2'd0
) (
   input  wire             cwusb_clk,
   input  wire             fpga_reset,
   input  wire reg_bus_t   bus,
   output reg_access_t     access,
   output logic            selected
);

   logic read_r;   // read level from the previous cycle

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         read_r <= 1'b0;
      end else begin
         read_r <= bus.read;
      end
   end

   // top two address bits pick the block
   assign selected = bus.addrvalid && (bus.address[7:6] == reg_select);

   always_comb begin
      access.addr     = reg_addr_e'(bus.address[5:0]);
      access.bytecnt  = bus.bytecnt;
      access.data     = bus.write_data;
      access.wr       = bus.write & selected;
      access.rd       = bus.read & selected;
      access.rd_first = bus.read & selected & ~read_r;   // rising edge of read
   end

endmodule

`default_nettype wire

//--- source/reg_main_pkg.sv
/* shared types and constants for the main register block.
   imported by every module that touches the register bus, FIFO or config outputs */

`default_nettype none

package reg_main_pkg;

   ////////////////////
   // widths
   ////////////////////

   localparam int bytecnt_w       = 7;
   localparam int capture_len_w   = 24;   // 3 bytes
   localparam int max_timestamp_w = 16;
   localparam int num_triggers_w  = 4;
   localparam int fe_select_w     = 2;

   // front-end select reset value
   localparam logic [fe_select_w-1:0] fe_usb = '0;

   ////////////////////
   // register map
   ////////////////////

   // offsets within the block, taken from address bits 5:0
   typedef enum logic [5:0] {
      reg_fe_select           = 6'd0,
      reg_arm                 = 6'd1,
      reg_trigger_enable      = 6'd2,
      reg_num_triggers        = 6'd3,
      reg_capture_len         = 6'd4,
      reg_count_writes        = 6'd5,
      reg_counter_quick_start = 6'd6,
      reg_capture_while_trig  = 6'd7,
      reg_max_timestamp       = 6'd8,
      reg_sniff_fifo_stat     = 6'd9,
      reg_sniff_fifo_rd       = 6'd10
   } reg_addr_e;

   ////////////////////
   // bus structs
   ////////////////////

   // raw register bus as it comes from the USB side
   typedef struct packed {
      logic [7:0]           address;
      logic [bytecnt_w-1:0] bytecnt;
      logic [7:0]           write_data;
      logic                 read;
      logic                 write;
      logic                 addrvalid;
   } reg_bus_t;

   // decoded access, already qualified by block select
   typedef struct packed {
      reg_addr_e            addr;
      logic [bytecnt_w-1:0] bytecnt;
      logic [7:0]           data;
      logic                 wr;         // write strobe
      logic                 rd;         // read level
      logic                 rd_first;   // first cycle of a read
   } reg_access_t;

   // sniff FIFO, first-word-fall-through
   typedef struct packed {
      logic [17:0] data;
      logic [5:0]  status;
      logic        empty;
   } fifo_in_t;

   // configuration outputs toward capture and trigger logic
   typedef struct packed {
      logic [fe_select_w-1:0]     fe_select;
      logic [capture_len_w-1:0]   capture_len;
      logic                       trigger_enable;
      logic [num_triggers_w-1:0]  num_triggers;
      logic                       count_writes;
      logic                       counter_quick_start;
      logic                       capture_while_trig;
      logic [max_timestamp_w-1:0] max_timestamp;
   } capture_cfg_t;

   ////////////////////
   // FIFO word codes
   ////////////////////

   localparam logic [1:0]  fifo_cmd_strm   = 2'b10;     // bits 17:16
   localparam logic [15:0] fifo_strm_empty = 16'h0001;  // bits 15:0

   // returned instead of data when a burst starts on an empty FIFO
   localparam logic [17:0] fifo_empty_word = {fifo_cmd_strm, fifo_strm_empty};

endpackage

`default_nettype wire
